//--- ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int WORD_W = 32;
    localparam int DWORD_W = 2 * WORD_W;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [DWORD_W-1:0] dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0] shamt_t;

    // opcode numbers are shared with the vector file
    typedef enum logic [5:0] {
        OP_NOP   = 6'd0,
        OP_OR    = 6'd1,
        OP_AND   = 6'd2,
        OP_XOR   = 6'd3,
        OP_NOR   = 6'd4,
        OP_SLL   = 6'd5,
        OP_SRL   = 6'd6,
        OP_SRA   = 6'd7,
        OP_ADD   = 6'd8,
        OP_ADDU  = 6'd9,
        OP_SUB   = 6'd10,
        OP_SUBU  = 6'd11,
        OP_SLT   = 6'd12,
        OP_SLTU  = 6'd13,
        OP_CLZ   = 6'd14,
        OP_CLO   = 6'd15,
        OP_MUL   = 6'd16,
        OP_MULT  = 6'd17,
        OP_MULTU = 6'd18,
        OP_MFHI  = 6'd19,
        OP_MFLO  = 6'd20,
        OP_MTHI  = 6'd21,
        OP_MTLO  = 6'd22
    } aluop_t;

    // result class picked in the later stages
    typedef enum logic [2:0] {
        RES_NONE  = 3'd0,
        RES_LOGIC = 3'd1,
        RES_SHIFT = 3'd2,
        RES_ARITH = 3'd3,
        RES_MUL   = 3'd4,
        RES_MOVE  = 3'd5
    } res_sel_t;

endpackage

`default_nettype wire

//--- ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ex_decode #(
    parameter int DATA_W = ex_pkg::WORD_W
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    in_valid_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire [DATA_W-1:0]       reg1_i,
    input  wire [DATA_W-1:0]       reg2_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire                    dec_ready_i,
    output logic                   in_ready_o,
    output logic                   dec_valid_o,
    output ex_pkg::aluop_t         op_o,
    output logic [DATA_W-1:0]      reg1_o,
    output logic [DATA_W-1:0]      reg2_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::res_sel_t       res_sel_o,
    output logic                   is_sub_o,
    output logic                   is_signed_cmp_o,
    output logic                   is_signed_mul_o,
    output logic                   ovf_check_o,
    output logic                   hi_we_o,
    output logic                   lo_we_o
);

    ex_pkg::res_sel_t sel_d;
    logic is_sub_d;
    logic is_signed_cmp_d;
    logic is_signed_mul_d;
    logic ovf_check_d;
    logic hi_we_d;
    logic lo_we_d;

    assign in_ready_o = !dec_valid_o || dec_ready_i;

    // opcode classification
    always_comb begin
        sel_d = ex_pkg::RES_NONE;
        is_sub_d = 1'b0;
        is_signed_cmp_d = 1'b0;
        is_signed_mul_d = 1'b0;
        ovf_check_d = 1'b0;
        hi_we_d = 1'b0;
        lo_we_d = 1'b0;
        case (aluop_i)
            ex_pkg::OP_OR, ex_pkg::OP_AND, ex_pkg::OP_XOR, ex_pkg::OP_NOR: begin
                sel_d = ex_pkg::RES_LOGIC;
            end
            ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA: begin
                sel_d = ex_pkg::RES_SHIFT;
            end
            ex_pkg::OP_ADD: begin
                sel_d = ex_pkg::RES_ARITH;
                ovf_check_d = 1'b1;
            end
            ex_pkg::OP_SUB: begin
                sel_d = ex_pkg::RES_ARITH;
                is_sub_d = 1'b1;
                ovf_check_d = 1'b1;
            end
            ex_pkg::OP_SUBU: begin
                sel_d = ex_pkg::RES_ARITH;
                is_sub_d = 1'b1;
            end
            ex_pkg::OP_SLT: begin
                sel_d = ex_pkg::RES_ARITH;
                is_sub_d = 1'b1;
                is_signed_cmp_d = 1'b1;
            end
            ex_pkg::OP_ADDU, ex_pkg::OP_SLTU, ex_pkg::OP_CLZ, ex_pkg::OP_CLO: begin
                sel_d = ex_pkg::RES_ARITH;
            end
            ex_pkg::OP_MUL: begin
                sel_d = ex_pkg::RES_MUL;
                is_signed_mul_d = 1'b1;
            end
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU: begin
                sel_d = ex_pkg::RES_MUL;
                is_signed_mul_d = (aluop_i == ex_pkg::OP_MULT);
                hi_we_d = 1'b1;
                lo_we_d = 1'b1;
            end
            ex_pkg::OP_MFHI, ex_pkg::OP_MFLO: begin
                sel_d = ex_pkg::RES_MOVE;
            end
            ex_pkg::OP_MTHI: begin
                sel_d = ex_pkg::RES_MOVE;
                hi_we_d = 1'b1;
            end
            ex_pkg::OP_MTLO: begin
                sel_d = ex_pkg::RES_MOVE;
                lo_we_d = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            op_o <= aluop_i;
            reg1_o <= reg1_i;
            reg2_o <= reg2_i;
            wd_o <= wd_i;
            // nop never writes the register file
            wreg_o <= wreg_i && (aluop_i != ex_pkg::OP_NOP);
            res_sel_o <= sel_d;
            is_sub_o <= is_sub_d;
            is_signed_cmp_o <= is_signed_cmp_d;
            is_signed_mul_o <= is_signed_mul_d;
            ovf_check_o <= ovf_check_d;
            hi_we_o <= hi_we_d;
            lo_we_o <= lo_we_d;
        end
    end

    a_class_known: assert property (@(posedge clk) disable iff (reset_i)
        dec_valid_o |-> (res_sel_o != ex_pkg::RES_NONE || op_o == ex_pkg::OP_NOP));

endmodule

`default_nettype wire

//--- ex_execute.sv
`timescale 1ns/1ps
`default_nettype none

module ex_execute #(
    parameter int DATA_W = ex_pkg::WORD_W
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    dec_valid_i,
    input  wire ex_pkg::aluop_t    op_i,
    input  wire [DATA_W-1:0]       reg1_i,
    input  wire [DATA_W-1:0]       reg2_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire ex_pkg::res_sel_t  res_sel_i,
    input  wire                    is_sub_i,
    input  wire                    is_signed_cmp_i,
    input  wire                    is_signed_mul_i,
    input  wire                    ovf_check_i,
    input  wire                    hi_we_i,
    input  wire                    lo_we_i,
    input  wire                    exe_ready_i,
    output logic                   dec_ready_o,
    output logic                   exe_valid_o,
    output logic [DATA_W-1:0]      value_o,
    output logic [2*DATA_W-1:0]    product_o,
    output logic [DATA_W-1:0]      reg1_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output ex_pkg::res_sel_t       res_sel_o,
    output ex_pkg::aluop_t         op_o,
    output logic                   hi_we_o,
    output logic                   lo_we_o
);

    localparam int CNT_W = $clog2(DATA_W) + 1;
    localparam int MSB = DATA_W - 1;

    ex_pkg::shamt_t shamt;
    logic [DATA_W-1:0] logic_val;
    logic [DATA_W-1:0] shift_val;
    logic [DATA_W-1:0] arith_val;
    logic [DATA_W-1:0] value_d;
    logic [DATA_W-1:0] addend;
    logic [DATA_W-1:0] sum;
    logic ovf;
    logic lt;
    logic [CNT_W-1:0] lead_cnt;
    logic [2*DATA_W-1:0] mul_a;
    logic [2*DATA_W-1:0] mul_b;
    logic [2*DATA_W-1:0] product;

    // leading zero count that gives the full width for a zero word
    function automatic logic [CNT_W-1:0] count_lead(input logic [DATA_W-1:0] v);
        logic [CNT_W-1:0] cnt;
        logic found;
        cnt = CNT_W'(DATA_W);
        found = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                cnt = CNT_W'(DATA_W - 1 - i);
                found = 1'b1;
            end
        end
        return cnt;
    endfunction

    assign dec_ready_o = !exe_valid_o || exe_ready_i;
    assign shamt = reg1_i[4:0];

    always_comb begin
        case (op_i)
            ex_pkg::OP_AND: logic_val = reg1_i & reg2_i;
            ex_pkg::OP_XOR: logic_val = reg1_i ^ reg2_i;
            ex_pkg::OP_NOR: logic_val = ~(reg1_i | reg2_i);
            default: logic_val = reg1_i | reg2_i;
        endcase
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_SRL: shift_val = reg2_i >> shamt;
            ex_pkg::OP_SRA: shift_val = DATA_W'($signed(reg2_i) >>> shamt);
            default: shift_val = reg2_i << shamt;
        endcase
    end

    // subtract as a plus the two's complement of b
    assign addend = is_sub_i ? (~reg2_i + DATA_W'(1)) : reg2_i;
    assign sum = reg1_i + addend;
    assign ovf = (reg1_i[MSB] == (reg2_i[MSB] ^ is_sub_i)) && (sum[MSB] != reg1_i[MSB]);
    assign lt = is_signed_cmp_i ? (sum[MSB] ^ ovf) : (reg1_i < reg2_i);
    assign lead_cnt = count_lead((op_i == ex_pkg::OP_CLO) ? ~reg1_i : reg1_i);

    always_comb begin
        case (op_i)
            ex_pkg::OP_SLT, ex_pkg::OP_SLTU: arith_val = DATA_W'(lt);
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO: arith_val = DATA_W'(lead_cnt);
            default: arith_val = sum;
        endcase
    end

    // sign or zero extend both operands for one wide multiply
    assign mul_a = {{DATA_W{is_signed_mul_i & reg1_i[MSB]}}, reg1_i};
    assign mul_b = {{DATA_W{is_signed_mul_i & reg2_i[MSB]}}, reg2_i};
    assign product = mul_a * mul_b;

    always_comb begin
        case (res_sel_i)
            ex_pkg::RES_LOGIC: value_d = logic_val;
            ex_pkg::RES_SHIFT: value_d = shift_val;
            ex_pkg::RES_ARITH: value_d = arith_val;
            ex_pkg::RES_MOVE: value_d = reg1_i;
            default: value_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exe_valid_o <= 1'b0;
        end else if (dec_ready_o) begin
            exe_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i && dec_ready_o) begin
            value_o <= value_d;
            product_o <= product;
            reg1_o <= reg1_i;
            wd_o <= wd_i;
            // add/sub overflow drops the write
            wreg_o <= wreg_i && !(ovf_check_i && ovf);
            res_sel_o <= res_sel_i;
            op_o <= op_i;
            hi_we_o <= hi_we_i;
            lo_we_o <= lo_we_i;
        end
    end

    // decode holds its item until this stage takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (reset_i)
        dec_valid_i && !dec_ready_o |=> dec_valid_i && $stable(op_i)
            && $stable(reg1_i) && $stable(reg2_i) && $stable(wd_i) && $stable(wreg_i));

endmodule

`default_nettype wire

//--- ex_result.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result #(
    parameter int DATA_W = ex_pkg::WORD_W
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    exe_valid_i,
    input  wire [DATA_W-1:0]       value_i,
    input  wire [2*DATA_W-1:0]     product_i,
    input  wire [DATA_W-1:0]       reg1_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire ex_pkg::res_sel_t  res_sel_i,
    input  wire ex_pkg::aluop_t    op_i,
    input  wire                    hi_we_i,
    input  wire                    lo_we_i,
    input  wire                    out_ready_i,
    output logic                   exe_ready_o,
    output logic                   out_valid_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output logic [DATA_W-1:0]      wdata_o,
    output logic [DATA_W-1:0]      hi_o,
    output logic [DATA_W-1:0]      lo_o
);

    logic accept;
    logic [DATA_W-1:0] hi_next;
    logic [DATA_W-1:0] lo_next;
    logic [DATA_W-1:0] wdata_d;

    assign exe_ready_o = !out_valid_o || out_ready_i;
    assign accept = exe_valid_i && exe_ready_o;

    // hi_o and lo_o are the architectural HI/LO and change in program order
    always_comb begin
        hi_next = hi_o;
        lo_next = lo_o;
        if (hi_we_i) begin
            hi_next = (op_i == ex_pkg::OP_MTHI) ? reg1_i : product_i[2*DATA_W-1:DATA_W];
        end
        if (lo_we_i) begin
            lo_next = (op_i == ex_pkg::OP_MTLO) ? reg1_i : product_i[DATA_W-1:0];
        end
    end

    // mfhi/mflo see HI/LO as left by the previous item
    always_comb begin
        case (res_sel_i)
            ex_pkg::RES_MUL: begin
                wdata_d = product_i[DATA_W-1:0];
            end
            ex_pkg::RES_MOVE: begin
                if (op_i == ex_pkg::OP_MFHI) begin
                    wdata_d = hi_o;
                end else if (op_i == ex_pkg::OP_MFLO) begin
                    wdata_d = lo_o;
                end else begin
                    wdata_d = value_i;
                end
            end
            default: begin
                wdata_d = value_i;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (exe_ready_o) begin
                out_valid_o <= exe_valid_i;
            end
            if (accept) begin
                hi_o <= hi_next;
                lo_o <= lo_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wd_o <= wd_i;
            wreg_o <= wreg_i;
            wdata_o <= wdata_d;
        end
    end

    // an item from execute waits here unchanged until it is taken
    a_valid_held: assert property (@(posedge clk) disable iff (reset_i)
        exe_valid_i && !exe_ready_o |=> exe_valid_i && $stable(value_i)
            && $stable(product_i) && $stable(wd_i) && $stable(wreg_i));

endmodule

`default_nettype wire

//--- ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
    parameter int DATA_W = ex_pkg::WORD_W
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    in_valid_i,
    input  wire ex_pkg::aluop_t    aluop_i,
    input  wire [DATA_W-1:0]       reg1_i,
    input  wire [DATA_W-1:0]       reg2_i,
    input  wire ex_pkg::reg_addr_t wd_i,
    input  wire                    wreg_i,
    input  wire                    out_ready_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    output ex_pkg::reg_addr_t      wd_o,
    output logic                   wreg_o,
    output logic [DATA_W-1:0]      wdata_o,
    output logic [DATA_W-1:0]      hi_o,
    output logic [DATA_W-1:0]      lo_o
);

    // decode to execute
    logic dec_valid;
    logic dec_ready;
    ex_pkg::aluop_t dec_op;
    logic [DATA_W-1:0] dec_reg1;
    logic [DATA_W-1:0] dec_reg2;
    ex_pkg::reg_addr_t dec_wd;
    logic dec_wreg;
    ex_pkg::res_sel_t dec_res_sel;
    logic dec_is_sub;
    logic dec_is_signed_cmp;
    logic dec_is_signed_mul;
    logic dec_ovf_check;
    logic dec_hi_we;
    logic dec_lo_we;

    // execute to result
    logic exe_valid;
    logic exe_ready;
    logic [DATA_W-1:0] exe_value;
    logic [2*DATA_W-1:0] exe_product;
    logic [DATA_W-1:0] exe_reg1;
    ex_pkg::reg_addr_t exe_wd;
    logic exe_wreg;
    ex_pkg::res_sel_t exe_res_sel;
    ex_pkg::aluop_t exe_op;
    logic exe_hi_we;
    logic exe_lo_we;

    ex_decode #(
        .DATA_W(DATA_W)
    ) u_decode (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .aluop_i         (aluop_i),
        .reg1_i          (reg1_i),
        .reg2_i          (reg2_i),
        .wd_i            (wd_i),
        .wreg_i          (wreg_i),
        .dec_ready_i     (dec_ready),
        .in_ready_o      (in_ready_o),
        .dec_valid_o     (dec_valid),
        .op_o            (dec_op),
        .reg1_o          (dec_reg1),
        .reg2_o          (dec_reg2),
        .wd_o            (dec_wd),
        .wreg_o          (dec_wreg),
        .res_sel_o       (dec_res_sel),
        .is_sub_o        (dec_is_sub),
        .is_signed_cmp_o (dec_is_signed_cmp),
        .is_signed_mul_o (dec_is_signed_mul),
        .ovf_check_o     (dec_ovf_check),
        .hi_we_o         (dec_hi_we),
        .lo_we_o         (dec_lo_we)
    );

    ex_execute #(
        .DATA_W(DATA_W)
    ) u_execute (
        .clk             (clk),
        .reset_i         (reset_i),
        .dec_valid_i     (dec_valid),
        .op_i            (dec_op),
        .reg1_i          (dec_reg1),
        .reg2_i          (dec_reg2),
        .wd_i            (dec_wd),
        .wreg_i          (dec_wreg),
        .res_sel_i       (dec_res_sel),
        .is_sub_i        (dec_is_sub),
        .is_signed_cmp_i (dec_is_signed_cmp),
        .is_signed_mul_i (dec_is_signed_mul),
        .ovf_check_i     (dec_ovf_check),
        .hi_we_i         (dec_hi_we),
        .lo_we_i         (dec_lo_we),
        .exe_ready_i     (exe_ready),
        .dec_ready_o     (dec_ready),
        .exe_valid_o     (exe_valid),
        .value_o         (exe_value),
        .product_o       (exe_product),
        .reg1_o          (exe_reg1),
        .wd_o            (exe_wd),
        .wreg_o          (exe_wreg),
        .res_sel_o       (exe_res_sel),
        .op_o            (exe_op),
        .hi_we_o         (exe_hi_we),
        .lo_we_o         (exe_lo_we)
    );

    ex_result #(
        .DATA_W(DATA_W)
    ) u_result (
        .clk         (clk),
        .reset_i     (reset_i),
        .exe_valid_i (exe_valid),
        .value_i     (exe_value),
        .product_i   (exe_product),
        .reg1_i      (exe_reg1),
        .wd_i        (exe_wd),
        .wreg_i      (exe_wreg),
        .res_sel_i   (exe_res_sel),
        .op_i        (exe_op),
        .hi_we_i     (exe_hi_we),
        .lo_we_i     (exe_lo_we),
        .out_ready_i (out_ready_i),
        .exe_ready_o (exe_ready),
        .out_valid_o (out_valid_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

endmodule

`default_nettype wire

//--- tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

    localparam int DATA_W = ex_pkg::WORD_W;
    localparam int CLK_PERIOD = 8;
    localparam int SETTLE_NS = 2;
    localparam int MAX_VEC = 64;
    localparam int WAIT_LIMIT = 100;

    logic clk;
    logic reset_i;
    logic in_valid_i;
    ex_pkg::aluop_t aluop_i;
    logic [DATA_W-1:0] reg1_i;
    logic [DATA_W-1:0] reg2_i;
    ex_pkg::reg_addr_t wd_i;
    logic wreg_i;
    logic out_ready_i;
    logic in_ready_o;
    logic out_valid_o;
    ex_pkg::reg_addr_t wd_o;
    logic wreg_o;
    logic [DATA_W-1:0] wdata_o;
    logic [DATA_W-1:0] hi_o;
    logic [DATA_W-1:0] lo_o;

    // one entry per vector line
    logic [5:0] vec_op [MAX_VEC];
    logic [DATA_W-1:0] vec_reg1 [MAX_VEC];
    logic [DATA_W-1:0] vec_reg2 [MAX_VEC];
    ex_pkg::reg_addr_t vec_wd [MAX_VEC];
    logic vec_wreg [MAX_VEC];
    logic [DATA_W-1:0] vec_wdata [MAX_VEC];
    logic vec_exp_wreg [MAX_VEC];
    logic [DATA_W-1:0] vec_hi [MAX_VEC];
    logic [DATA_W-1:0] vec_lo [MAX_VEC];
    int num_vec;
    logic [15:0] lfsr_state;

    ex_top #(
        .DATA_W(DATA_W)
    ) DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o),
        .hi_o        (hi_o),
        .lo_o        (lo_o)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        stop_with_error($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                  $time, name, got, exp));
    endtask

    task automatic load_vectors();
        int fd;
        int code;
        string line;
        logic [31:0] c_op;
        logic [31:0] c_r1;
        logic [31:0] c_r2;
        logic [31:0] c_wd;
        logic [31:0] c_wreg;
        logic [31:0] c_wdata;
        logic [31:0] c_ewreg;
        logic [31:0] c_hi;
        logic [31:0] c_lo;
        fd = $fopen("ex_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open ex_vectors.txt");
        end
        num_vec = 0;
        while ($fgets(line, fd) > 0) begin
            // skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", c_op, c_r1, c_r2,
                               c_wd, c_wreg, c_wdata, c_ewreg, c_hi, c_lo);
                if (code != 9) begin
                    stop_with_error("a line of ex_vectors.txt does not have nine columns");
                end
                if (num_vec == MAX_VEC) begin
                    stop_with_error("ex_vectors.txt holds more vectors than the table");
                end
                vec_op[num_vec] = c_op[5:0];
                vec_reg1[num_vec] = c_r1;
                vec_reg2[num_vec] = c_r2;
                vec_wd[num_vec] = c_wd[4:0];
                vec_wreg[num_vec] = c_wreg[0];
                vec_wdata[num_vec] = c_wdata;
                vec_exp_wreg[num_vec] = c_ewreg[0];
                vec_hi[num_vec] = c_hi;
                vec_lo[num_vec] = c_lo;
                num_vec++;
            end
        end
        $fclose(fd);
        if (num_vec == 0) begin
            stop_with_error("no vectors found in ex_vectors.txt");
        end
    endtask

    // present each operation until the unit takes it
    task automatic drive_inputs();
        int waited;
        for (int i = 0; i < num_vec; i++) begin
            @(negedge clk);
            in_valid_i = 1'b1;
            aluop_i = ex_pkg::aluop_t'(vec_op[i]);
            reg1_i = vec_reg1[i];
            reg2_i = vec_reg2[i];
            wd_i = vec_wd[i];
            wreg_i = vec_wreg[i];
            waited = 0;
            // in_ready_o follows out_ready_i through the stages
            #(SETTLE_NS);
            while (!in_ready_o) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    stop_with_error("the unit did not accept an operation in time");
                end
                @(negedge clk);
                #(SETTLE_NS);
            end
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic compare_result(input int idx);
        assert (wd_o == vec_wd[idx])
            else report_mismatch("wd_o", DATA_W'(wd_o), DATA_W'(vec_wd[idx]));
        assert (wreg_o == vec_exp_wreg[idx])
            else report_mismatch("wreg_o", DATA_W'(wreg_o), DATA_W'(vec_exp_wreg[idx]));
        assert (wdata_o == vec_wdata[idx])
            else report_mismatch("wdata_o", wdata_o, vec_wdata[idx]);
        assert (hi_o == vec_hi[idx])
            else report_mismatch("hi_o", hi_o, vec_hi[idx]);
        assert (lo_o == vec_lo[idx])
            else report_mismatch("lo_o", lo_o, vec_lo[idx]);
    endtask

    task automatic check_outputs();
        int idx;
        int idle;
        logic held;
        ex_pkg::reg_addr_t held_wd;
        logic held_wreg;
        logic [DATA_W-1:0] held_wdata;
        logic [DATA_W-1:0] held_hi;
        logic [DATA_W-1:0] held_lo;
        idx = 0;
        idle = 0;
        held = 1'b0;
        while (idx < num_vec) begin
            @(negedge clk);
            if (held) begin
                assert (out_valid_o)
                    else stop_with_error("out_valid_o fell while the output was held");
                assert (wd_o == held_wd)
                    else report_mismatch("wd_o", DATA_W'(wd_o), DATA_W'(held_wd));
                assert (wreg_o == held_wreg)
                    else report_mismatch("wreg_o", DATA_W'(wreg_o), DATA_W'(held_wreg));
                assert (wdata_o == held_wdata)
                    else report_mismatch("wdata_o", wdata_o, held_wdata);
                assert (hi_o == held_hi)
                    else report_mismatch("hi_o", hi_o, held_hi);
                assert (lo_o == held_lo)
                    else report_mismatch("lo_o", lo_o, held_lo);
            end
            lfsr_state = lfsr_step(lfsr_state);
            out_ready_i = lfsr_state[0];
            held = out_valid_o && !out_ready_i;
            held_wd = wd_o;
            held_wreg = wreg_o;
            held_wdata = wdata_o;
            held_hi = hi_o;
            held_lo = lo_o;
            if (out_valid_o && out_ready_i) begin
                compare_result(idx);
                idx++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    stop_with_error("no output transfer within the timeout");
                end
            end
        end
        // nothing may follow the last vector
        repeat (5) begin
            @(negedge clk);
            assert (!out_valid_o)
                else stop_with_error("an output appeared after the last vector");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_i = 1'b1;
        in_valid_i = 1'b0;
        aluop_i = ex_pkg::OP_NOP;
        reg1_i = '0;
        reg2_i = '0;
        wd_i = '0;
        wreg_i = 1'b0;
        out_ready_i = 1'b0;
        lfsr_state = 16'd89;
        load_vectors();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        fork
            drive_inputs();
            check_outputs();
        join
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- ex_vectors.txt
# op reg1 reg2 wd wreg | expected: wdata wreg hi lo (all hex)
# opcodes follow ex_pkg::aluop_t, hi/lo are the values after the operation
01 F0F01234 0F0F4321 01 1 FFFF5335 1 00000000 00000000
02 F0F01234 FF00FF0F 02 1 F0001204 1 00000000 00000000
03 AAAA5555 FFFF0000 03 1 55555555 1 00000000 00000000
04 000000FF 0F000000 04 1 F0FFFF00 1 00000000 00000000
05 00000024 00001234 05 1 00012340 1 00000000 00000000
06 00000008 80001200 06 1 00800012 1 00000000 00000000
07 00000004 80001200 07 1 F8000120 1 00000000 00000000
07 0000001F 80000000 08 1 FFFFFFFF 1 00000000 00000000
08 00000005 00000007 09 1 0000000C 1 00000000 00000000
08 7FFFFFFF 00000001 0A 1 80000000 0 00000000 00000000
09 7FFFFFFF 00000001 0B 1 80000000 1 00000000 00000000
0A 80000000 00000001 0C 1 7FFFFFFF 0 00000000 00000000
0A 00000003 00000005 0D 1 FFFFFFFE 1 00000000 00000000
0B 80000000 00000001 0E 1 7FFFFFFF 1 00000000 00000000
0C FFFFFFFF 00000001 0F 1 00000001 1 00000000 00000000
0D FFFFFFFF 00000001 10 1 00000000 1 00000000 00000000
0C 80000000 7FFFFFFF 11 1 00000001 1 00000000 00000000
0E 00000000 00000000 12 1 00000020 1 00000000 00000000
0E 00010000 00000000 13 1 0000000F 1 00000000 00000000
0E FFFFFFFF 00000000 14 1 00000000 1 00000000 00000000
0F FFFFFFFF 00000000 15 1 00000020 1 00000000 00000000
0F 00000000 00000000 16 1 00000000 1 00000000 00000000
10 FFFFFFFE 00000003 17 1 FFFFFFFA 1 00000000 00000000
11 80000000 00000003 00 0 80000000 0 FFFFFFFE 80000000
14 00000000 00000000 18 1 80000000 1 FFFFFFFE 80000000
13 00000000 00000000 19 1 FFFFFFFE 1 FFFFFFFE 80000000
12 80000000 00000003 00 0 80000000 0 00000001 80000000
13 00000000 00000000 1A 1 00000001 1 00000001 80000000
15 12345678 00000000 00 0 12345678 0 12345678 80000000
16 9ABCDEF0 00000000 00 0 9ABCDEF0 0 12345678 9ABCDEF0
13 00000000 00000000 1B 1 12345678 1 12345678 9ABCDEF0
14 00000000 00000000 1C 1 9ABCDEF0 1 12345678 9ABCDEF0
00 11111111 22222222 1D 1 00000000 0 12345678 9ABCDEF0
11 00010000 00010000 00 0 00000000 0 00000001 00000000
14 00000000 00000000 1E 1 00000000 1 00000001 00000000

//--- sources.f
ex_pkg.sv
ex_decode.sv
ex_execute.sv
ex_result.sv
ex_top.sv
tb_ex_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execution unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_ex_top -o sim_tb_ex_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_ex_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
